// ==== bench/sdram_controller_tb.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_controller_tb;
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;

    // About 120 cycles of init and 1000 of tests leave ample margin
    localparam int TIMEOUT_CYCLES = 6000;

    logic                           sdram_clock;
    logic                           sdram_reset;
    sdram_host_addr_t               address;
    logic [`SDRAM_COL_WIDTH-1:0]    access_num;
    logic [`SDRAM_DATA_WIDTH-1:0]   data_in;
    logic [`SDRAM_DATA_WIDTH-1:0]   data_out;
    logic                           write_request;
    logic                           read_request;
    logic                           enable_refresh;
    logic                           write_flag;
    logic                           read_flag;
    logic                           idle;
    sdram_abus_u                    sdram_address;
    logic                           sdram_cke;
    logic                           sdram_cs;
    logic                           sdram_ras;
    logic                           sdram_cas;
    logic                           sdram_we;
    logic [`SDRAM_BANK_WIDTH-1:0]   sdram_ba;
    logic [`SDRAM_DATA_WIDTH-1:0]   sdram_dq_in;
    logic [`SDRAM_DATA_WIDTH-1:0]   sdram_dq_out;
    logic                           sdram_dq_io;

    integer                         seed;
    int                             cycle_count = 0;
    int                             check_count = 0;
    int                             error_count = 0;
    int                             tests_run = 0;
    int                             tests_failed = 0;
    int                             test_start_errors;
    int                             start_cycle;
    int                             wr_seen;
    int                             rd_seen;
    int                             first_wr;
    int                             first_rd;
    int                             last_refresh;
    int                             refresh_count;
    int                             max_gap;
    int                             total_errors;
    logic [`SDRAM_DATA_WIDTH-1:0]   wr_data [0:255];
    logic [`SDRAM_DATA_WIDTH-1:0]   rd_data [0:255];

    sdram_controller DUT (.*);

    sdram_model sdram_mem (.*);

    bind sdram_controller sdram_protocol_chk u_protocol_chk (
        .sdram_clock    (sdram_clock),
        .sdram_reset    (sdram_reset),
        .sdram_cke      (sdram_cke),
        .sdram_cs       (sdram_cs),
        .sdram_ras      (sdram_ras),
        .sdram_cas      (sdram_cas),
        .sdram_we       (sdram_we),
        .sdram_dq_io    (sdram_dq_io),
        .write_flag     (write_flag),
        .read_flag      (read_flag)
    );

    always #4 sdram_clock = ~sdram_clock;

    always @(posedge sdram_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected)
        else begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_true(input string name, input logic cond, input string what);
        check_count++;
        assert (cond)
        else begin
            $display("%s: %s", name, what);
            error_count++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (error_count == test_start_errors) begin
            $display("Test %-10s done, no errors", name);
        end else begin
            tests_failed++;
            $display("Test %-10s done, %0d errors", name, error_count - test_start_errors);
        end
    endtask

    task automatic wait_idle();
        do
            @(posedge sdram_clock);
        while (!idle);
    endtask

    task automatic fill_random(input int n);
        for (int i = 0; i < n; i++)
            wr_data[i] = $random(seed);
    endtask

    // Raise the requests, feed write words, collect read words until each access ends
    task automatic run_access(input logic wr, input logic rd, input sdram_host_addr_t addr,
                              input int n);
        int   target;
        int   episodes;
        logic was_idle;
        logic wr_dropped;
        target     = wr + rd;
        episodes   = 0;
        was_idle   = 1'b1;
        wr_dropped = 1'b0;
        wr_seen    = 0;
        rd_seen    = 0;
        first_wr   = -1;
        first_rd   = -1;
        wait_idle();
        address       <= addr;
        access_num    <= n[`SDRAM_COL_WIDTH-1:0];
        data_in       <= wr_data[0];
        write_request <= wr;
        read_request  <= rd;
        while (episodes < target) begin
            @(posedge sdram_clock);
            if (write_flag) begin
                if (first_wr < 0)
                    first_wr = cycle_count;
                wr_seen++;
            end
            if (read_flag) begin
                if (first_rd < 0)
                    first_rd = cycle_count;
                rd_data[rd_seen] = data_out;
                rd_seen++;
            end
            data_in <= wr_data[wr_seen];
            // Write wins, so the first access served is the write
            if (was_idle && !idle) begin
                if (wr && !wr_dropped) begin
                    write_request <= 1'b0;
                    wr_dropped = 1'b1;
                end else begin
                    read_request <= 1'b0;
                end
            end
            if (!was_idle && idle)
                episodes++;
            was_idle = idle;
        end
    endtask

    task automatic compare_words(input string name, input int n);
        for (int k = 0; k < n; k++)
            check_value($sformatf("%s word %0d", name, k), wr_data[k], rd_data[k]);
    endtask

    function automatic logic is_refresh_cmd();
        return !sdram_cs && ({sdram_ras, sdram_cas, sdram_we} == CMD_REFRESH);
    endfunction

    initial begin
        seed           = 32'h4e4c_be2e;
        sdram_clock    = 1'b0;
        sdram_reset    = 1'b1;
        address        = '0;
        access_num     = '0;
        data_in        = '0;
        write_request  = 1'b0;
        read_request   = 1'b0;
        enable_refresh = 1'b0;
        repeat (3) @(posedge sdram_clock);
        sdram_reset <= 1'b0;

        test_start_errors = error_count;
        start_cycle = cycle_count;
        wait_idle();
        check_true("power_up", (cycle_count - start_cycle) >= `SDRAM_INIT_WAIT,
                   "idle rose before the power-up wait was over");
        check_true("power_up", sdram_mem.cmd_log.size() >= 4,
                   "fewer than four commands were issued before idle");
        if (sdram_mem.cmd_log.size() >= 4) begin
            check_value("power_up cmd 0", {1'b1, CMD_PRECHARGE}, sdram_mem.cmd_log[0]);
            check_value("power_up cmd 1", CMD_REFRESH, sdram_mem.cmd_log[1][2:0]);
            check_value("power_up cmd 2", CMD_REFRESH, sdram_mem.cmd_log[2][2:0]);
            check_value("power_up cmd 3", CMD_MODE, sdram_mem.cmd_log[3][2:0]);
        end
        check_value("power_up cas latency", `SDRAM_CAS_LATENCY,
                    sdram_mem.mode_reg.mode.cas_latency);
        report_test("power_up");

        test_start_errors = error_count;
        fill_random(8);
        run_access(1'b1, 1'b0, {2'd0, 12'h005, 8'h10}, 8);
        check_value("burst write flags", 8, wr_seen);
        run_access(1'b0, 1'b1, {2'd0, 12'h005, 8'h10}, 8);
        check_value("burst read flags", 8, rd_seen);
        compare_words("burst", 8);
        report_test("burst");

        test_start_errors = error_count;
        fill_random(1);
        run_access(1'b1, 1'b0, {2'd2, 12'h7a3, 8'h40}, 1);
        run_access(1'b0, 1'b1, {2'd2, 12'h7a3, 8'h40}, 1);
        compare_words("single", 1);
        // Word must sit at bank 2, row 7a3, column 40 of the SDRAM array
        check_value("single bank and row", wr_data[0],
                    sdram_mem.mem[{2'd2, 12'h7a3, 8'h40}]);
        fill_random(10);
        run_access(1'b1, 1'b0, {2'd2, 12'h7a3, 8'd250}, 10);
        run_access(1'b0, 1'b1, {2'd2, 12'h7a3, 8'd250}, 10);
        compare_words("wrap", 10);
        // 250 + 8 wraps to column 2
        run_access(1'b0, 1'b1, {2'd2, 12'h7a3, 8'd2}, 1);
        check_value("wrap column 2", wr_data[8], rd_data[0]);
        report_test("wrap");

        test_start_errors = error_count;
        fill_random(4);
        run_access(1'b1, 1'b1, {2'd0, 12'h005, 8'h10}, 4);
        check_true("priority", (first_wr >= 0) && (first_rd > first_wr),
                   "write_flag did not rise before read_flag");
        check_value("priority write flags", 4, wr_seen);
        check_value("priority read flags", 4, rd_seen);
        compare_words("priority", 4);
        report_test("priority");

        test_start_errors = error_count;
        enable_refresh <= 1'b1;
        last_refresh  = cycle_count;
        refresh_count = 0;
        max_gap       = 0;
        repeat (3 * (`SDRAM_REFRESH_CYCLE + 10)) begin
            @(posedge sdram_clock);
            if (is_refresh_cmd()) begin
                if ((cycle_count - last_refresh) > max_gap)
                    max_gap = cycle_count - last_refresh;
                last_refresh = cycle_count;
                refresh_count++;
            end
        end
        if ((cycle_count - last_refresh) > max_gap)
            max_gap = cycle_count - last_refresh;
        check_true("refresh", max_gap <= (`SDRAM_REFRESH_CYCLE + 10),
                   $sformatf("refresh gap of %0d cycles is too long", max_gap));
        check_true("refresh", refresh_count >= 3,
                   $sformatf("only %0d refresh commands while enabled", refresh_count));
        enable_refresh <= 1'b0;
        // Let a refresh already under way finish
        repeat (10) @(posedge sdram_clock);
        refresh_count = 0;
        repeat (300) begin
            @(posedge sdram_clock);
            if (is_refresh_cmd())
                refresh_count++;
        end
        check_value("refresh disabled count", 0, refresh_count);
        report_test("refresh");

        total_errors = error_count + DUT.u_protocol_chk.violations;
        $display("Tests %0d, failed %0d, checks %0d, errors %0d, protocol violations %0d",
                 tests_run, tests_failed, check_count, error_count,
                 DUT.u_protocol_chk.violations);
        if (total_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== bench/sdram_model.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_model (
    input  logic                                sdram_clock,
    input  logic                                sdram_cke,
    input  logic                                sdram_cs,
    input  logic                                sdram_ras,
    input  logic                                sdram_cas,
    input  logic                                sdram_we,
    input  logic [`SDRAM_BANK_WIDTH-1:0]        sdram_ba,
    input  sdram_addr_pkg::sdram_abus_u         sdram_address,
    input  logic [`SDRAM_DATA_WIDTH-1:0]        sdram_dq_out,
    input  logic                                sdram_dq_io,
    output logic [`SDRAM_DATA_WIDTH-1:0]        sdram_dq_in
);
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;

    localparam int MEM_WORDS = 1 << `SDRAM_ADDR_WIDTH;

    logic [`SDRAM_DATA_WIDTH-1:0]   mem [0:MEM_WORDS-1];
    logic [`SDRAM_ROW_WIDTH-1:0]    open_row [0:(1 << `SDRAM_BANK_WIDTH)-1];
    logic [`SDRAM_DATA_WIDTH-1:0]   read_pipe [0:`SDRAM_CAS_LATENCY-1];
    logic [`SDRAM_ADDR_WIDTH-1:0]   word_index;
    logic [2:0]                     cmd;
    sdram_abus_u                    mode_reg;

    // {A10, ras, cas, we} of every command other than NOP
    logic [3:0]                     cmd_log [$];

    assign cmd        = sdram_cs ? CMD_NOP : {sdram_ras, sdram_cas, sdram_we};
    assign word_index = {sdram_ba, open_row[sdram_ba], sdram_address.col.column};

    always @(posedge sdram_clock) begin
        read_pipe[0] <= 'x;
        if (sdram_cke && (cmd != CMD_NOP)) begin
            cmd_log.push_back({sdram_address.col.all_banks, cmd});
            case (cmd)
                CMD_ACTIVE: open_row[sdram_ba] <= sdram_address.row;
                CMD_WRITE: begin
                    if (!sdram_dq_io)
                        mem[word_index] <= sdram_dq_out;
                end
                CMD_READ:   read_pipe[0] <= mem[word_index];
                CMD_MODE:   mode_reg <= sdram_address;
                default: begin
                    // Precharge and refresh leave no state here
                end
            endcase
        end
        for (int i = 1; i < `SDRAM_CAS_LATENCY; i++)
            read_pipe[i] <= read_pipe[i-1];
    end

    // Word is on the bus CAS latency edges after the read command
    assign sdram_dq_in = read_pipe[`SDRAM_CAS_LATENCY-1];

endmodule

// ==== bench/sdram_protocol_chk.sv ====
`timescale 1ns/1ps

module sdram_protocol_chk (
    input  logic    sdram_clock,
    input  logic    sdram_reset,
    input  logic    sdram_cke,
    input  logic    sdram_cs,
    input  logic    sdram_ras,
    input  logic    sdram_cas,
    input  logic    sdram_we,
    input  logic    sdram_dq_io,
    input  logic    write_flag,
    input  logic    read_flag
);
    import sdram_cmd_pkg::*;

    logic [2:0] cmd;
    logic       mode_seen;
    int         violations = 0;

    assign cmd = sdram_cs ? CMD_NOP : {sdram_ras, sdram_cas, sdram_we};

    always_ff @(posedge sdram_clock or posedge sdram_reset) begin
        if (sdram_reset)
            mode_seen <= 1'b0;
        else if (cmd == CMD_MODE)
            mode_seen <= 1'b1;
    end

    dq_only_with_write: assert property (@(posedge sdram_clock) disable iff (sdram_reset)
        !sdram_dq_io |-> (cmd == CMD_WRITE))
    else begin
        $error("data bus driven without a write command");
        violations++;
    end

    flags_exclusive: assert property (@(posedge sdram_clock) disable iff (sdram_reset)
        !(write_flag && read_flag))
    else begin
        $error("write_flag and read_flag high together");
        violations++;
    end

    cke_stays_high: assert property (@(posedge sdram_clock) disable iff (sdram_reset)
        sdram_cke |=> sdram_cke)
    else begin
        $error("cke dropped after power-up");
        violations++;
    end

    no_active_before_mode: assert property (@(posedge sdram_clock) disable iff (sdram_reset)
        (cmd == CMD_ACTIVE) |-> mode_seen)
    else begin
        $error("row opened before the mode register was set");
        violations++;
    end

endmodule

// ==== source/sdram_addr_pkg.sv ====
`include "sdram_params.svh"

package sdram_addr_pkg;

    typedef struct packed {
        logic [`SDRAM_BANK_WIDTH-1:0]   bank;
        logic [`SDRAM_ROW_WIDTH-1:0]    row;
        logic [`SDRAM_COL_WIDTH-1:0]    col;
    } sdram_host_addr_t;

    // Column access with A10 as the all-banks precharge bit
    typedef struct packed {
        logic [`SDRAM_ROW_WIDTH-12:0]   reserved;
        logic                           all_banks;
        logic [9-`SDRAM_COL_WIDTH:0]    pad;
        logic [`SDRAM_COL_WIDTH-1:0]    column;
    } sdram_col_view_t;

    // Mode register layout
    typedef struct packed {
        logic [`SDRAM_ROW_WIDTH-11:0]   reserved;
        logic                           write_burst;
        logic [1:0]                     op_mode;
        logic [2:0]                     cas_latency;
        logic                           burst_type;
        logic [2:0]                     burst_length;
    } sdram_mode_view_t;

    typedef union packed {
        logic [`SDRAM_ROW_WIDTH-1:0]    row;
        sdram_col_view_t                col;
        sdram_mode_view_t               mode;
    } sdram_abus_u;

endpackage

// ==== source/sdram_cmd_pkg.sv ====
package sdram_cmd_pkg;

    typedef enum logic [3:0] {
        INIT,
        PALL,
        INIT_CBR_1,
        INIT_CBR_2,
        MRS,
        REFRESH_PALL,
        REFRESH,
        IDLE,
        WRITE,
        PRECHARGE_WAIT,
        READ,
        PRECHARGE
    } sdram_state_t;

    // Active-low patterns on {ras, cas, we}
    localparam logic [2:0] CMD_NOP       = 3'b111;
    localparam logic [2:0] CMD_ACTIVE    = 3'b011;
    localparam logic [2:0] CMD_READ      = 3'b101;
    localparam logic [2:0] CMD_WRITE     = 3'b100;
    localparam logic [2:0] CMD_PRECHARGE = 3'b010;
    localparam logic [2:0] CMD_REFRESH   = 3'b001;
    localparam logic [2:0] CMD_MODE      = 3'b000;

endpackage

// ==== source/sdram_command_encoder.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_command_encoder (
    input  logic                                sdram_clock,
    input  logic                                sdram_reset,
    input  sdram_cmd_pkg::sdram_state_t         state,
    input  sdram_cmd_pkg::sdram_state_t         next_state,
    input  logic [`SDRAM_COUNT_WIDTH-1:0]       state_counter,
    input  logic [`SDRAM_COL_WIDTH-1:0]         access_counter,
    input  logic                                end_read_cmd,
    input  sdram_addr_pkg::sdram_host_addr_t    address,
    input  logic [`SDRAM_DATA_WIDTH-1:0]        data_in,
    output sdram_addr_pkg::sdram_abus_u         sdram_address,
    output logic                                sdram_cke,
    output logic                                sdram_cs,
    output logic                                sdram_ras,
    output logic                                sdram_cas,
    output logic                                sdram_we,
    output logic [`SDRAM_BANK_WIDTH-1:0]        sdram_ba,
    output logic [`SDRAM_DATA_WIDTH-1:0]        sdram_dq_out,
    output logic                                sdram_dq_io
);
    import sdram_cmd_pkg::*;

    logic send_cmd;

    // Timed states issue their command on the first cycle only
    assign send_cmd = (state_counter == '0);

    always_ff @(posedge sdram_clock or posedge sdram_reset) begin
        if (sdram_reset) begin
            sdram_address <= '0;
            sdram_cke     <= 1'b0;
            sdram_cs      <= 1'b1;
            sdram_ras     <= 1'b1;
            sdram_cas     <= 1'b1;
            sdram_we      <= 1'b1;
            sdram_ba      <= '0;
            sdram_dq_out  <= '0;
            sdram_dq_io   <= 1'b1;
        end else begin
            // NOP with the bus released unless a state says otherwise
            sdram_address <= '0;
            sdram_cke     <= 1'b1;
            sdram_cs      <= 1'b0;
            {sdram_ras, sdram_cas, sdram_we} <= CMD_NOP;
            sdram_ba      <= '0;
            sdram_dq_out  <= '0;
            sdram_dq_io   <= 1'b1;

            case (state)
                PALL, REFRESH_PALL, PRECHARGE: begin
                    sdram_address.col.all_banks <= 1'b1;
                    if (send_cmd)
                        {sdram_ras, sdram_cas, sdram_we} <= CMD_PRECHARGE;
                end
                INIT_CBR_1, INIT_CBR_2, REFRESH: begin
                    if (send_cmd)
                        {sdram_ras, sdram_cas, sdram_we} <= CMD_REFRESH;
                end
                MRS: begin
                    if (send_cmd) begin
                        // Burst length 1, sequential, burst write
                        sdram_address.mode.cas_latency <= `SDRAM_CAS_LATENCY;
                        {sdram_ras, sdram_cas, sdram_we} <= CMD_MODE;
                    end
                end
                IDLE: begin
                    // Open the row on the way out of IDLE
                    if ((next_state == WRITE) || (next_state == READ)) begin
                        sdram_address.row <= address.row;
                        sdram_ba          <= address.bank;
                        {sdram_ras, sdram_cas, sdram_we} <= CMD_ACTIVE;
                    end
                end
                WRITE: begin
                    sdram_address.col.column <= address.col + access_counter;
                    sdram_ba     <= address.bank;
                    {sdram_ras, sdram_cas, sdram_we} <= CMD_WRITE;
                    sdram_dq_out <= data_in;
                    sdram_dq_io  <= 1'b0;
                end
                READ: begin
                    if (!end_read_cmd) begin
                        sdram_address.col.column <= address.col + access_counter;
                        sdram_ba <= address.bank;
                        {sdram_ras, sdram_cas, sdram_we} <= CMD_READ;
                    end
                end
                default: begin
                    // INIT and PRECHARGE_WAIT hold NOP
                end
            endcase
        end
    end

endmodule

// ==== source/sdram_controller.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_controller (
    input  logic                                sdram_clock,
    input  logic                                sdram_reset,
    input  sdram_addr_pkg::sdram_host_addr_t    address,
    input  logic [`SDRAM_COL_WIDTH-1:0]         access_num,
    input  logic [`SDRAM_DATA_WIDTH-1:0]        data_in,
    output logic [`SDRAM_DATA_WIDTH-1:0]        data_out,
    input  logic                                write_request,
    input  logic                                read_request,
    input  logic                                enable_refresh,
    output logic                                write_flag,
    output logic                                read_flag,
    output logic                                idle,
    output sdram_addr_pkg::sdram_abus_u         sdram_address,
    output logic                                sdram_cke,
    output logic                                sdram_cs,
    output logic                                sdram_ras,
    output logic                                sdram_cas,
    output logic                                sdram_we,
    output logic [`SDRAM_BANK_WIDTH-1:0]        sdram_ba,
    input  logic [`SDRAM_DATA_WIDTH-1:0]        sdram_dq_in,
    output logic [`SDRAM_DATA_WIDTH-1:0]        sdram_dq_out,
    output logic                                sdram_dq_io
);
    import sdram_cmd_pkg::*;

    sdram_state_t                   state;
    sdram_state_t                   next_state;
    logic [`SDRAM_COUNT_WIDTH-1:0]  state_counter;
    logic [`SDRAM_COL_WIDTH-1:0]    access_counter;
    logic                           end_read_cmd;
    logic                           refresh_due;

    // Read data passes straight through to the host
    assign data_out = sdram_dq_in;

    sdram_sequencer u_sequencer (
        .sdram_clock    (sdram_clock),
        .sdram_reset    (sdram_reset),
        .write_request  (write_request),
        .read_request   (read_request),
        .refresh_due    (refresh_due),
        .access_num     (access_num),
        .state          (state),
        .next_state     (next_state),
        .state_counter  (state_counter),
        .access_counter (access_counter),
        .end_read_cmd   (end_read_cmd),
        .write_flag     (write_flag),
        .read_flag      (read_flag),
        .idle           (idle)
    );

    sdram_refresh_timer u_refresh_timer (
        .sdram_clock    (sdram_clock),
        .sdram_reset    (sdram_reset),
        .enable_refresh (enable_refresh),
        .sdram_cs       (sdram_cs),
        .sdram_ras      (sdram_ras),
        .sdram_cas      (sdram_cas),
        .sdram_we       (sdram_we),
        .refresh_due    (refresh_due)
    );

    sdram_command_encoder u_command_encoder (
        .sdram_clock    (sdram_clock),
        .sdram_reset    (sdram_reset),
        .state          (state),
        .next_state     (next_state),
        .state_counter  (state_counter),
        .access_counter (access_counter),
        .end_read_cmd   (end_read_cmd),
        .address        (address),
        .data_in        (data_in),
        .sdram_address  (sdram_address),
        .sdram_cke      (sdram_cke),
        .sdram_cs       (sdram_cs),
        .sdram_ras      (sdram_ras),
        .sdram_cas      (sdram_cas),
        .sdram_we       (sdram_we),
        .sdram_ba       (sdram_ba),
        .sdram_dq_out   (sdram_dq_out),
        .sdram_dq_io    (sdram_dq_io)
    );

endmodule

// ==== source/sdram_params.svh ====
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// Bus widths
`define SDRAM_COL_WIDTH         8
`define SDRAM_ROW_WIDTH         12
`define SDRAM_BANK_WIDTH        2
`define SDRAM_DATA_WIDTH        16

// Host address is bank, row and column packed together
`define SDRAM_ADDR_WIDTH        (`SDRAM_COL_WIDTH + `SDRAM_ROW_WIDTH + `SDRAM_BANK_WIDTH)

// Last count of each timed state (cycles minus one)
`define SDRAM_TRC               4
`define SDRAM_TRP               0
`define SDRAM_TMRD              1
`define SDRAM_TDPL              1

`define SDRAM_CAS_LATENCY       3'd2

// Power-up wait and refresh interval in cycles
`define SDRAM_INIT_WAIT         100
`define SDRAM_REFRESH_CYCLE     100

`define SDRAM_COUNT_WIDTH       16

`endif

// ==== source/sdram_refresh_timer.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_refresh_timer (
    input  logic    sdram_clock,
    input  logic    sdram_reset,
    input  logic    enable_refresh,
    input  logic    sdram_cs,
    input  logic    sdram_ras,
    input  logic    sdram_cas,
    input  logic    sdram_we,
    output logic    refresh_due
);
    import sdram_cmd_pkg::*;

    logic [`SDRAM_COUNT_WIDTH-1:0] refresh_counter;
    logic                          refresh_seen;

    // Any refresh on the pins restarts the interval
    assign refresh_seen = !sdram_cs && ({sdram_ras, sdram_cas, sdram_we} == CMD_REFRESH);

    always_ff @(posedge sdram_clock or posedge sdram_reset) begin
        if (sdram_reset)
            refresh_counter <= '0;
        else if (refresh_seen)
            refresh_counter <= '0;
        else if (refresh_counter != `SDRAM_REFRESH_CYCLE)
            refresh_counter <= refresh_counter + 1'b1;
    end

    assign refresh_due = enable_refresh && (refresh_counter == `SDRAM_REFRESH_CYCLE);

endmodule

// ==== source/sdram_sequencer.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_sequencer (
    input  logic                                sdram_clock,
    input  logic                                sdram_reset,
    input  logic                                write_request,
    input  logic                                read_request,
    input  logic                                refresh_due,
    input  logic [`SDRAM_COL_WIDTH-1:0]         access_num,
    output sdram_cmd_pkg::sdram_state_t         state,
    output sdram_cmd_pkg::sdram_state_t         next_state,
    output logic [`SDRAM_COUNT_WIDTH-1:0]       state_counter,
    output logic [`SDRAM_COL_WIDTH-1:0]         access_counter,
    output logic                                end_read_cmd,
    output logic                                write_flag,
    output logic                                read_flag,
    output logic                                idle
);
    import sdram_cmd_pkg::*;

    logic [`SDRAM_COL_WIDTH-1:0] read_counter;

    // Read commands stop once access_num columns are issued
    assign end_read_cmd = state_counter >= access_num;

    always_comb begin
        next_state = state;
        case (state)
            INIT: begin
                if (state_counter == `SDRAM_INIT_WAIT)
                    next_state = PALL;
            end
            PALL: begin
                if (state_counter == `SDRAM_TRP)
                    next_state = INIT_CBR_1;
            end
            INIT_CBR_1: begin
                if (state_counter == `SDRAM_TRC)
                    next_state = INIT_CBR_2;
            end
            INIT_CBR_2: begin
                if (state_counter == `SDRAM_TRC)
                    next_state = MRS;
            end
            MRS: begin
                if (state_counter == `SDRAM_TMRD)
                    next_state = IDLE;
            end
            REFRESH_PALL: begin
                if (state_counter == `SDRAM_TRP)
                    next_state = REFRESH;
            end
            REFRESH: begin
                if (state_counter == `SDRAM_TRC)
                    next_state = IDLE;
            end
            IDLE: begin
                // Write before read before refresh
                if (write_request)
                    next_state = WRITE;
                else if (read_request)
                    next_state = READ;
                else if (refresh_due)
                    next_state = REFRESH_PALL;
            end
            WRITE: begin
                if (access_counter == access_num - 1'b1)
                    next_state = PRECHARGE_WAIT;
            end
            PRECHARGE_WAIT: begin
                if (state_counter == `SDRAM_TDPL)
                    next_state = PRECHARGE;
            end
            READ: begin
                if (end_read_cmd && (read_counter == access_num))
                    next_state = PRECHARGE;
            end
            PRECHARGE: begin
                if (state_counter == `SDRAM_TRP)
                    next_state = IDLE;
            end
            default: begin
                next_state = INIT;
            end
        endcase
    end

    always_ff @(posedge sdram_clock or posedge sdram_reset) begin
        if (sdram_reset)
            state <= INIT;
        else
            state <= next_state;
    end

    // Cleared on every state change
    always_ff @(posedge sdram_clock or posedge sdram_reset) begin
        if (sdram_reset)
            state_counter <= '0;
        else if (next_state != state)
            state_counter <= '0;
        else
            state_counter <= state_counter + 1'b1;
    end

    always_ff @(posedge sdram_clock or posedge sdram_reset) begin
        if (sdram_reset)
            access_counter <= '0;
        else if ((state == WRITE) || (state == READ))
            access_counter <= access_counter + 1'b1;
        else
            access_counter <= '0;
    end

    // Words returned after the CAS latency
    always_ff @(posedge sdram_clock or posedge sdram_reset) begin
        if (sdram_reset)
            read_counter <= '0;
        else if (state != READ)
            read_counter <= '0;
        else if (state_counter <= `SDRAM_CAS_LATENCY)
            read_counter <= '0;
        else if (read_counter != access_num)
            read_counter <= read_counter + 1'b1;
    end

    assign idle       = (state == IDLE);
    assign write_flag = (state == WRITE);
    assign read_flag  = (state == READ) && (next_state == READ)
                        && (state_counter > `SDRAM_CAS_LATENCY);

endmodule

// ==== vlog.f ====
+incdir+source
source/sdram_cmd_pkg.sv
source/sdram_addr_pkg.sv
source/sdram_sequencer.sv
source/sdram_refresh_timer.sv
source/sdram_command_encoder.sv
source/sdram_controller.sv
bench/sdram_model.sv
bench/sdram_protocol_chk.sv
bench/sdram_controller_tb.sv
